// File: compile.f
+incdir+include
logic/isa_pkg.sv
logic/core_pkg.sv
logic/pipe_control.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/apb_port.sv
logic/mips_top.sv
test/tb_mips.sv

// File: Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f compile.f --top-module tb_mips -o Vtb_mips

run: build
	./obj_dir/Vtb_mips | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f compile.f --top-module mips_top

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_mips.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module tb_mips;
    import isa_pkg::*;

    typedef logic [31:0] mem16_t [16];

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   psel = 1'b0;
    logic                   penable = 1'b0;
    logic                   pwrite = 1'b0;
    logic [`APB_ADDR_W-1:0] paddr = '0;
    logic [31:0]            pwdata = '0;
    logic [31:0]            prdata;
    logic                   pready, pslverr;

    logic [31:0] prog [$];
    logic [31:0] rng_state = 32'hfdd8_6cee;
    int          checks = 0;
    int          errors = 0;
    int          errors_before = 0;
    int          wait_cycles = 0;  // access cycles with pready low in the last transfer
    funct_e      fns [13] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
                              fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
    opcode_e     iops [7] = '{op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu};

    mips_top UUT (.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
                  .pslverr);

    always #4 clk = ~clk;

    function automatic logic [31:0] rtype(funct_e fn, int rd, int rs, int rt, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] itype(opcode_e op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jump(int target);
        return {6'h02, 26'(target)};
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // one instruction per step, no pipeline
    function automatic mem16_t ref_run();
        logic [31:0] r [32];
        logic [31:0] m [256];
        logic [31:0] ins, a, b, res, simm, zimm;
        mem16_t      out;
        int          pc, npc, dst;
        logic        wr;
        foreach (r[i]) r[i] = '0;
        foreach (m[i]) m[i] = '0;
        pc = 0;
        for (int step = 0; step < 2000 && pc < prog.size(); step++) begin
            ins = prog[pc];
            if (ins == jump(pc))
                break;  // parked on the final self loop
            a = r[ins[25:21]];
            b = r[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            zimm = {16'h0000, ins[15:0]};
            npc = pc + 1;
            wr = 1'b1;
            dst = ins[20:16];
            res = '0;
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h00: res = b << ins[10:6];
                        6'h02: res = b >> ins[10:6];
                        6'h03: res = $signed(b) >>> ins[10:6];
                        6'h20, 6'h21: res = a + b;
                        6'h22, 6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h27: res = ~(a | b);
                        6'h2a: res = 32'($signed(a) < $signed(b));
                        6'h2b: res = 32'(a < b);
                        default: wr = 1'b0;
                    endcase
                end
                6'h08, 6'h09: res = a + simm;
                6'h0a: res = 32'($signed(a) < $signed(simm));
                6'h0b: res = 32'(a < simm);
                6'h0c: res = a & zimm;
                6'h0d: res = a | zimm;
                6'h0e: res = a ^ zimm;
                6'h23: res = m[((a + simm) >> 2) & 255];
                6'h2b: begin
                    m[((a + simm) >> 2) & 255] = b;
                    wr = 1'b0;
                end
                6'h04: begin
                    wr = 1'b0;
                    if (a == b) npc = (pc + 1 + int'($signed(simm))) & 255;
                end
                6'h05: begin
                    wr = 1'b0;
                    if (a != b) npc = (pc + 1 + int'($signed(simm))) & 255;
                end
                6'h02: begin
                    wr = 1'b0;
                    npc = ins[7:0];
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 0)
                r[dst] = res;
            pc = npc;
        end
        foreach (out[i]) out[i] = m[i];
        return out;
    endfunction

    task automatic fail_timeout(string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic apb_xfer(logic wr, logic [11:0] addr, logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        int t;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        t = 0;
        while (!pready) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 20)
                fail_timeout("pready");
        end
        wait_cycles = t;
        rdata = prdata;  // stable until the completing edge
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(logic [11:0] addr, logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(logic [11:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic expect_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_and_start();
        logic err;
        for (int i = 0; i < 16; i++) begin
            apb_write(12'(`APB_DMEM_BASE + 4 * i), '0, err);
            expect_value("pslverr dmem write", 32'(err), 32'h0);
        end
        foreach (prog[i]) begin
            apb_write(12'(`APB_IMEM_BASE + 4 * i), prog[i], err);
            expect_value("pslverr imem write", 32'(err), 32'h0);
        end
        apb_write(`APB_CTRL_ADDR, 32'h1, err);
        expect_value("pslverr ctrl write", 32'(err), 32'h0);
        expect_value("pready wait states", 32'(wait_cycles), 32'h0);
    endtask

    task automatic stop_core();
        logic err;
        apb_write(`APB_CTRL_ADDR, 32'h0, err);
        expect_value("pslverr ctrl write", 32'(err), 32'h0);
        repeat (8) @(posedge clk);  // let in-flight work drain
    endtask

    task automatic run_and_compare();
        mem16_t      exp;
        logic [31:0] d;
        logic        err;
        load_and_start();
        repeat (200) @(posedge clk);
        stop_core();
        exp = ref_run();
        for (int i = 0; i < 16; i++) begin
            apb_read(12'(`APB_DMEM_BASE + 4 * i), d, err);
            expect_value($sformatf("prdata dmem[%0d]", i), d, exp[i]);
            expect_value("pslverr", 32'(err), 32'h0);
            expect_value("pready wait states", 32'(wait_cycles), 32'h1);
        end
    endtask

    task automatic end_test(int n, string name);
        $display("test %0d %s: %0d errors", n, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic build_random();
        logic [31:0] x;
        int          k, sel;
        prog.delete();
        k = 0;
        for (int r = 1; r < 8; r++)
            prog.push_back(itype(op_addiu, r, 0, int'(next_rand() & 32'hffff)));
        for (int i = 0; i < 20; i++) begin
            x = next_rand();
            sel = (x >> 12) % 20;
            if (sel < 13)
                prog.push_back(rtype(fns[sel], 1 + x % 7, 1 + (x >> 4) % 7,
                                     1 + (x >> 8) % 7, (x >> 20) % 32));
            else
                prog.push_back(itype(iops[sel - 13], 1 + x % 7, 1 + (x >> 4) % 7,
                                     int'(x >> 16)));
            if (i % 4 == 3) begin  // store the fresh result
                prog.push_back(itype(op_sw, 1 + x % 7, 0, 4 * k));
                k++;
            end
        end
        prog.push_back(jump(prog.size()));
    endtask

    initial begin
        logic [31:0] d;
        logic        err;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        apb_read(`APB_CTRL_ADDR, d, err);
        expect_value("prdata ctrl", d, 32'h0);
        expect_value("pslverr ctrl", 32'(err), 32'h0);
        expect_value("pready wait states", 32'(wait_cycles), 32'h0);
        apb_read(`APB_IMEM_BASE, d, err);
        expect_value("pslverr imem read", 32'(err), 32'h1);
        expect_value("pready wait states", 32'(wait_cycles), 32'h0);
        end_test(1, "reset state");

        prog = '{itype(op_addiu, 1, 0, 5), rtype(fn_addu, 2, 1, 1, 0),
                 rtype(fn_sub, 3, 2, 1, 0), itype(op_ori, 4, 3, 16'hf0f0),
                 rtype(fn_xor, 5, 4, 2, 0), itype(op_sw, 5, 0, 0),
                 rtype(fn_nor, 6, 5, 3, 0), itype(op_sw, 6, 0, 4),
                 rtype(fn_slt, 7, 6, 1, 0), itype(op_sw, 7, 0, 8),
                 rtype(fn_sll, 8, 0, 4, 3), rtype(fn_sra, 9, 0, 6, 2),
                 rtype(fn_srl, 10, 0, 6, 4), itype(op_sw, 8, 0, 12),
                 itype(op_sw, 9, 0, 16), itype(op_sw, 10, 0, 20), jump(16)};
        run_and_compare();
        end_test(2, "dependent chain");

        prog = '{itype(op_addiu, 1, 0, 16'h55), itype(op_sw, 1, 0, 0),
                 itype(op_lw, 2, 0, 0), rtype(fn_addu, 3, 2, 2, 0),
                 itype(op_sw, 3, 0, 4), itype(op_lw, 4, 0, 4), itype(op_sw, 4, 0, 8),
                 itype(op_addiu, 5, 0, 12), itype(op_lw, 6, 5, -8),
                 rtype(fn_sub, 7, 6, 1, 0), itype(op_sw, 7, 5, 0), jump(11)};
        run_and_compare();
        end_test(3, "load use");

        prog = '{itype(op_addiu, 1, 0, 3), itype(op_addiu, 2, 0, 3),
                 itype(op_beq, 2, 1, 1), itype(op_sw, 1, 0, 0),
                 itype(op_bne, 2, 1, 1), itype(op_sw, 2, 0, 4),
                 itype(op_addiu, 3, 0, 7), itype(op_bne, 1, 3, 1),
                 itype(op_sw, 3, 0, 8), itype(op_beq, 1, 3, 1),
                 itype(op_sw, 3, 0, 12), jump(13), itype(op_sw, 1, 0, 16),
                 itype(op_sw, 2, 0, 20), jump(14)};
        run_and_compare();
        end_test(4, "branches");

        prog = '{jump(0)};
        load_and_start();
        apb_write(12'(`APB_DMEM_BASE + 12), 32'hdead_beef, err);
        expect_value("pslverr busy write", 32'(err), 32'h1);
        expect_value("pready wait states", 32'(wait_cycles), 32'h0);
        apb_read(12'(`APB_DMEM_BASE + 12), d, err);
        expect_value("pslverr busy read", 32'(err), 32'h1);
        expect_value("pready wait states", 32'(wait_cycles), 32'h0);
        stop_core();
        apb_read(12'(`APB_DMEM_BASE + 12), d, err);
        expect_value("prdata dmem[3]", d, 32'h0);
        apb_write(12'(`APB_DMEM_BASE + 12), 32'h1234_5678, err);
        expect_value("pslverr dmem write", 32'(err), 32'h0);
        apb_read(12'(`APB_DMEM_BASE + 12), d, err);
        expect_value("prdata dmem[3]", d, 32'h1234_5678);
        end_test(5, "busy access");

        for (int n = 0; n < 10; n++) begin
            build_random();
            run_and_compare();
        end
        end_test(6, "random programs");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end
endmodule

// File: logic/mips_top.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module mips_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  core_pkg::word_t        pwdata,
    output core_pkg::word_t        prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import isa_pkg::*;
    import core_pkg::*;

    logic      run, start, imem_we, dmem_we;
    imem_idx_t imem_waddr, pc_next_d, branch_target;
    dmem_idx_t dmem_addr;
    word_t     dmem_wdata, dmem_rdata, instr_d, rd1, rd2, rd1_d, rd2_d;
    word_t     alu_out_m, store_data_m, wb_data;
    alu_op_e   alu_op;
    logic      src_imm, src_shamt, zero_ext, mem_read, mem_write, reg_write, dst_rd;
    logic      stall, flush_f, flush_d, branch_taken;
    fwd_sel_e  fwd_rs_d, fwd_rt_d, fwd_rs_e, fwd_rt_e;
    reg_addr_t dest_e, dest_m, dest_w, rs_e, rt_e;
    logic      wen_e, wen_m, wen_w, load_e, load_m, mem_write_m;

    apb_port u_apb (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .run, .start, .imem_we, .imem_waddr, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rdata
    );

    fetch_stage u_fetch (
        .clk, .reset, .run, .start, .stall, .flush(flush_f), .branch_taken, .branch_target,
        .imem_we, .imem_waddr, .imem_wdata(pwdata), .instr_d, .pc_next_d
    );

    pipe_control u_ctrl (
        .instr_d, .pc_next_d, .rd1_d, .rd2_d, .dest_e, .dest_m, .dest_w, .wen_e, .wen_m,
        .wen_w, .load_e, .load_m, .rs_e, .rt_e, .alu_op, .src_imm, .src_shamt, .zero_ext,
        .mem_read, .mem_write, .reg_write, .dst_rd, .stall, .flush_f, .flush_d, .fwd_rs_d,
        .fwd_rt_d, .fwd_rs_e, .fwd_rt_e, .branch_taken, .branch_target
    );

    reg_file u_regs (
        .clk, .rs(instr_d[25:21]), .rt(instr_d[20:16]), .wen(wen_w), .waddr(dest_w),
        .wdata(wb_data), .rd1, .rd2
    );

    exec_stage u_exec (
        .clk, .reset, .flush(flush_d), .alu_op, .src_imm, .src_shamt, .zero_ext, .mem_read,
        .mem_write, .reg_write, .dst_rd, .rd1, .rd2, .instr_d, .fwd_rs_d, .fwd_rt_d,
        .fwd_rs_e, .fwd_rt_e, .wb_data, .rd1_d, .rd2_d, .alu_out_m, .store_data_m, .dest_e,
        .dest_m, .wen_e, .wen_m, .load_e, .load_m, .mem_write_m, .rs_e, .rt_e
    );

    mem_stage u_mem (
        .clk, .reset, .alu_out_m, .store_data_m, .dest_m, .wen_m, .load_m, .mem_write_m,
        .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rdata, .dest_w, .wen_w, .wb_data
    );
endmodule

// File: logic/apb_port.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module apb_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  core_pkg::word_t        pwdata,
    output core_pkg::word_t        prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   run,
    output logic                   start,
    output logic                   imem_we,
    output core_pkg::imem_idx_t    imem_waddr,
    output logic                   dmem_we,
    output core_pkg::dmem_idx_t    dmem_addr,
    output core_pkg::word_t        dmem_wdata,
    input  core_pkg::word_t        dmem_rdata
);
    import core_pkg::*;

    apb_state_e state;
    logic       in_imem, in_dmem, in_ctrl;
    logic       bad_access, slow_read, done;

    assign in_imem    = (paddr & `APB_REGION_MASK) == `APB_IMEM_BASE;
    assign in_dmem    = (paddr & `APB_REGION_MASK) == `APB_DMEM_BASE;
    assign in_ctrl    = paddr == `APB_CTRL_ADDR;
    assign bad_access = (in_imem && !pwrite) || (in_dmem && run) ||
                        !(in_imem || in_dmem || in_ctrl);
    assign slow_read  = in_dmem && !pwrite && !run;  // registered ram read
    assign done       = state == apb_access && pready;

    assign imem_waddr = imem_idx_t'(paddr >> 2);
    assign dmem_addr  = dmem_idx_t'(paddr >> 2);
    assign dmem_wdata = pwdata;
    assign imem_we    = done && pwrite && in_imem;
    assign dmem_we    = done && pwrite && in_dmem && !pslverr;
    assign prdata     = (state == apb_read_wait) ? dmem_rdata : word_t'(run);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= apb_idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            run     <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                apb_idle: begin
                    if (psel && !penable) begin  // setup phase
                        state   <= apb_access;
                        pready  <= !slow_read;
                        pslverr <= bad_access;
                    end
                end
                apb_access: begin
                    if (pready) begin
                        state   <= apb_idle;
                        pready  <= 1'b0;
                        pslverr <= 1'b0;
                        if (pwrite && in_ctrl) begin
                            run   <= pwdata[0];
                            start <= pwdata[0];
                        end
                    end else begin
                        state  <= apb_read_wait;
                        pready <= 1'b1;
                    end
                end
                default: begin
                    state  <= apb_idle;
                    pready <= 1'b0;
                end
            endcase
        end
    end
endmodule

// File: logic/mem_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module mem_stage (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::word_t     alu_out_m,
    input  core_pkg::word_t     store_data_m,
    input  core_pkg::reg_addr_t dest_m,
    input  logic                wen_m,
    input  logic                load_m,
    input  logic                mem_write_m,
    input  logic                dmem_we,
    input  core_pkg::dmem_idx_t dmem_addr,
    input  core_pkg::word_t     dmem_wdata,
    output core_pkg::word_t     dmem_rdata,
    output core_pkg::reg_addr_t dest_w,
    output logic                wen_w,
    output core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t     dmem [`MIPS_DMEM_WORDS];
    dmem_idx_t pipe_idx;
    word_t     load_data_w;
    word_t     alu_w;
    logic      load_w;

    assign pipe_idx = dmem_idx_t'(alu_out_m >> 2);  // byte address to word

    // apb only writes while halted, so the two writers never collide
    always_ff @(posedge clk) begin
        if (mem_write_m)
            dmem[pipe_idx] <= store_data_m;
        else if (dmem_we)
            dmem[dmem_addr] <= dmem_wdata;
        dmem_rdata  <= dmem[dmem_addr];
        load_data_w <= dmem[pipe_idx];
        alu_w       <= alu_out_m;
        dest_w      <= dest_m;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wen_w  <= 1'b0;
            load_w <= 1'b0;
        end else begin
            wen_w  <= wen_m;
            load_w <= load_m;
        end
    end

    assign wb_data = load_w ? load_data_w : alu_w;
endmodule

// File: logic/exec_stage.sv
`timescale 1ns/100ps
module exec_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  isa_pkg::alu_op_e    alu_op,
    input  logic                src_imm,
    input  logic                src_shamt,
    input  logic                zero_ext,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                reg_write,
    input  logic                dst_rd,
    input  core_pkg::word_t     rd1,
    input  core_pkg::word_t     rd2,
    input  core_pkg::word_t     instr_d,
    input  core_pkg::fwd_sel_e  fwd_rs_d,
    input  core_pkg::fwd_sel_e  fwd_rt_d,
    input  core_pkg::fwd_sel_e  fwd_rs_e,
    input  core_pkg::fwd_sel_e  fwd_rt_e,
    input  core_pkg::word_t     wb_data,
    output core_pkg::word_t     rd1_d,
    output core_pkg::word_t     rd2_d,
    output core_pkg::word_t     alu_out_m,
    output core_pkg::word_t     store_data_m,
    output core_pkg::reg_addr_t dest_e,
    output core_pkg::reg_addr_t dest_m,
    output logic                wen_e,
    output logic                wen_m,
    output logic                load_e,
    output logic                load_m,
    output logic                mem_write_m,
    output core_pkg::reg_addr_t rs_e,
    output core_pkg::reg_addr_t rt_e
);
    import isa_pkg::*;
    import core_pkg::*;

    alu_op_e    alu_op_q;
    logic       src_imm_q, src_shamt_q, mem_write_q;
    word_t      a_q, b_q, imm_q;
    logic [4:0] shamt_q;
    word_t      imm_ext, fwd_a, fwd_b, op_a, op_b, alu_result;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t base, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_from_mem: return mem_val;
            fwd_from_wb:  return wb_val;
            default:      return base;
        endcase
    endfunction

    // decode side operands, also used for the branch compare
    assign rd1_d   = fwd_mux(fwd_rs_d, rd1, alu_out_m, wb_data);
    assign rd2_d   = fwd_mux(fwd_rt_d, rd2, alu_out_m, wb_data);
    assign imm_ext = zero_ext ? {16'h0000, instr_d[15:0]} : {{16{instr_d[15]}}, instr_d[15:0]};

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wen_e       <= 1'b0;
            load_e      <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            wen_e       <= reg_write;
            load_e      <= mem_read;
            mem_write_q <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        alu_op_q    <= alu_op;
        src_imm_q   <= src_imm;
        src_shamt_q <= src_shamt;
        dest_e      <= dst_rd ? instr_d[15:11] : instr_d[20:16];
        rs_e        <= instr_d[25:21];
        rt_e        <= instr_d[20:16];
        shamt_q     <= instr_d[10:6];
        a_q         <= rd1_d;
        b_q         <= rd2_d;
        imm_q       <= imm_ext;
    end

    assign fwd_a = fwd_mux(fwd_rs_e, a_q, alu_out_m, wb_data);
    assign fwd_b = fwd_mux(fwd_rt_e, b_q, alu_out_m, wb_data);
    assign op_a  = src_shamt_q ? word_t'(shamt_q) : fwd_a;
    assign op_b  = src_imm_q ? imm_q : fwd_b;

    always_comb begin
        case (alu_op_q)
            alu_and:  alu_result = op_a & op_b;
            alu_or:   alu_result = op_a | op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_slt:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result = word_t'(op_a < op_b);
            alu_xor:  alu_result = op_a ^ op_b;
            alu_nor:  alu_result = ~(op_a | op_b);
            alu_sll:  alu_result = op_b << op_a[4:0];  // shift amount rides on operand a
            alu_srl:  alu_result = op_b >> op_a[4:0];
            alu_sra:  alu_result = word_t'($signed(op_b) >>> op_a[4:0]);
            default:  alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wen_m       <= 1'b0;
            load_m      <= 1'b0;
            mem_write_m <= 1'b0;
        end else begin
            wen_m       <= wen_e;
            load_m      <= load_e;
            mem_write_m <= mem_write_q;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_m    <= alu_result;
        store_data_m <= fwd_b;
        dest_m       <= dest_e;
    end
endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module reg_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs,
    input  core_pkg::reg_addr_t rt,
    input  logic                wen,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rd1,
    output core_pkg::word_t     rd2
);
    import core_pkg::*;

    word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (wen)
            regs[waddr] <= wdata;
    end

    // r0 reads zero, otherwise writeback data bypasses the array
    assign rd1 = (rs == '0) ? '0 : (wen && waddr == rs) ? wdata : regs[rs];
    assign rd2 = (rt == '0) ? '0 : (wen && waddr == rt) ? wdata : regs[rt];
endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"
module fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                start,
    input  logic                stall,
    input  logic                flush,
    input  logic                branch_taken,
    input  core_pkg::imem_idx_t branch_target,
    input  logic                imem_we,
    input  core_pkg::imem_idx_t imem_waddr,
    input  core_pkg::word_t     imem_wdata,
    output core_pkg::word_t     instr_d,
    output core_pkg::imem_idx_t pc_next_d
);
    import core_pkg::*;

    word_t     imem [`MIPS_IMEM_WORDS];
    imem_idx_t pc;
    imem_idx_t pc_plus1;

    assign pc_plus1 = pc + 1'b1;

    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_waddr] <= imem_wdata;
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            pc        <= '0;
            instr_d   <= `MIPS_NOP;
            pc_next_d <= '0;
        end else if (!stall) begin
            if (run)
                pc <= branch_taken ? branch_target : pc_plus1;  // pc frozen while halted
            instr_d   <= (run && !flush) ? imem[pc] : `MIPS_NOP;
            pc_next_d <= pc_plus1;
        end
    end
endmodule

// File: logic/pipe_control.sv
`timescale 1ns/100ps
module pipe_control (
    input  core_pkg::word_t     instr_d,
    input  core_pkg::imem_idx_t pc_next_d,
    input  core_pkg::word_t     rd1_d,
    input  core_pkg::word_t     rd2_d,
    input  core_pkg::reg_addr_t dest_e,
    input  core_pkg::reg_addr_t dest_m,
    input  core_pkg::reg_addr_t dest_w,
    input  logic                wen_e,
    input  logic                wen_m,
    input  logic                wen_w,
    input  logic                load_e,
    input  logic                load_m,
    input  core_pkg::reg_addr_t rs_e,
    input  core_pkg::reg_addr_t rt_e,
    output isa_pkg::alu_op_e    alu_op,
    output logic                src_imm,
    output logic                src_shamt,
    output logic                zero_ext,
    output logic                mem_read,
    output logic                mem_write,
    output logic                reg_write,
    output logic                dst_rd,
    output logic                stall,
    output logic                flush_f,
    output logic                flush_d,
    output core_pkg::fwd_sel_e  fwd_rs_d,
    output core_pkg::fwd_sel_e  fwd_rt_d,
    output core_pkg::fwd_sel_e  fwd_rs_e,
    output core_pkg::fwd_sel_e  fwd_rt_e,
    output logic                branch_taken,
    output core_pkg::imem_idx_t branch_target
);
    import isa_pkg::*;
    import core_pkg::*;

    reg_addr_t rs_d;
    reg_addr_t rt_d;
    logic      is_beq, is_bne, is_j;
    logic      load_use, branch_wait;

    function automatic logic hit(reg_addr_t src, logic wen, reg_addr_t dest);
        return wen && src != '0 && src == dest;
    endfunction

    assign rs_d = instr_d[25:21];
    assign rt_d = instr_d[20:16];

    always_comb begin
        alu_op    = alu_add;
        src_imm   = 1'b0;
        src_shamt = 1'b0;
        zero_ext  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        dst_rd    = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode_e'(instr_d[31:26]))
            op_rtype: begin
                reg_write = 1'b1;
                dst_rd    = 1'b1;
                case (funct_e'(instr_d[5:0]))
                    fn_add, fn_addu: alu_op = alu_add;
                    fn_sub, fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll: begin
                        alu_op    = alu_sll;
                        src_shamt = 1'b1;
                    end
                    fn_srl: begin
                        alu_op    = alu_srl;
                        src_shamt = 1'b1;
                    end
                    fn_sra: begin
                        alu_op    = alu_sra;
                        src_shamt = 1'b1;
                    end
                    default: reg_write = 1'b0;  // unknown funct is a no-op
                endcase
            end
            op_addi, op_addiu: {src_imm, reg_write} = 2'b11;
            op_slti: begin
                alu_op = alu_slt;
                {src_imm, reg_write} = 2'b11;
            end
            op_sltiu: begin
                alu_op = alu_sltu;  // imm still sign extended
                {src_imm, reg_write} = 2'b11;
            end
            op_andi: begin
                alu_op = alu_and;
                {src_imm, reg_write, zero_ext} = 3'b111;
            end
            op_ori: begin
                alu_op = alu_or;
                {src_imm, reg_write, zero_ext} = 3'b111;
            end
            op_xori: begin
                alu_op = alu_xor;
                {src_imm, reg_write, zero_ext} = 3'b111;
            end
            op_lw:   {src_imm, reg_write, mem_read} = 3'b111;
            op_sw:   {src_imm, mem_write} = 2'b11;
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            op_j:    is_j = 1'b1;
            default: ;
        endcase
    end

    // nearer stage wins, loads in mem are not forwarded into decode
    assign fwd_rs_d = hit(rs_d, wen_m && !load_m, dest_m) ? fwd_from_mem : fwd_none;
    assign fwd_rt_d = hit(rt_d, wen_m && !load_m, dest_m) ? fwd_from_mem : fwd_none;
    assign fwd_rs_e = hit(rs_e, wen_m, dest_m) ? fwd_from_mem :
                      hit(rs_e, wen_w, dest_w) ? fwd_from_wb : fwd_none;
    assign fwd_rt_e = hit(rt_e, wen_m, dest_m) ? fwd_from_mem :
                      hit(rt_e, wen_w, dest_w) ? fwd_from_wb : fwd_none;

    assign load_use    = hit(rs_d, load_e, dest_e) || hit(rt_d, load_e, dest_e);
    assign branch_wait = (is_beq || is_bne) &&
                         (hit(rs_d, wen_e, dest_e) || hit(rt_d, wen_e, dest_e) ||
                          hit(rs_d, load_m, dest_m) || hit(rt_d, load_m, dest_m));
    assign stall   = load_use || branch_wait;
    assign flush_d = stall;  // bubble into execute

    assign branch_taken = !stall && (is_j || (is_beq && rd1_d == rd2_d) ||
                                     (is_bne && rd1_d != rd2_d));
    assign flush_f      = branch_taken;
    assign branch_target = is_j ? imem_idx_t'(instr_d) : pc_next_d + imem_idx_t'(instr_d);
endmodule

// File: logic/core_pkg.sv
package core_pkg;

`include "mips_consts.svh"

    typedef logic [`MIPS_XLEN-1:0]                word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0]   reg_addr_t;
    typedef logic [$clog2(`MIPS_IMEM_WORDS)-1:0]  imem_idx_t;  // word index, pc counts words
    typedef logic [$clog2(`MIPS_DMEM_WORDS)-1:0]  dmem_idx_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    typedef enum logic [1:0] {
        apb_idle,
        apb_access,
        apb_read_wait
    } apb_state_e;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_sltiu = 6'h0b,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    // no overflow traps, so signed and unsigned add/sub share a code
    typedef enum logic [3:0] {
        alu_and  = 4'b0000,
        alu_or   = 4'b0001,
        alu_add  = 4'b0010,
        alu_sub  = 4'b0110,
        alu_slt  = 4'b0111,
        alu_sltu = 4'b1000,
        alu_xor  = 4'b1001,
        alu_sll  = 4'b1010,
        alu_srl  = 4'b1011,
        alu_nor  = 4'b1100,
        alu_sra  = 4'b1101
    } alu_op_e;

endpackage

// File: include/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN        32
`define MIPS_REG_COUNT   32
`define MIPS_IMEM_WORDS  256
`define MIPS_DMEM_WORDS  256

// all-zero word decodes as sll r0,r0,0
`define MIPS_NOP         32'h0000_0000

`define APB_ADDR_W       12
`define APB_REGION_MASK  12'hc00
`define APB_IMEM_BASE    12'h000
`define APB_DMEM_BASE    12'h400
`define APB_CTRL_ADDR    12'h800

`endif
